// File: design/alu.sv
/*
  alu
  ten arithmetic, logic, compare and shift operations with a zero flag
*/

`timescale 1ns/100ps

module alu
	import cpu_types_pkg::*;
	import data_path_muxs_pkg::*;
(
	input  word_t  a,
	input  word_t  b,
	input  aluop_t aluop,
	output word_t  result,
	output logic   zero
);

	// shift amount sits in the low bits of a
	logic [4:0] shamt;

	assign shamt = a[4:0];

	always_comb begin
		case (aluop)
			// shifts move b by a
			alu_sll:  result = b << shamt;
			alu_srl:  result = b >> shamt;
			alu_add:  result = a + b;
			alu_sub:  result = a - b;
			alu_and:  result = a & b;
			alu_or:   result = a | b;
			alu_xor:  result = a ^ b;
			alu_nor:  result = ~(a | b);
			// set on less than, signed then unsigned
			alu_slt:  result = word_t'($signed(a) < $signed(b));
			alu_sltu: result = word_t'(a < b);
			default:  result = '0;
		endcase
	end

	// beq and bne read this as equal
	assign zero = (result == '0);

endmodule

// File: design/control_unit.sv
/*
  control unit
  decodes an instruction word into every datapath control of the single cycle core
*/

`timescale 1ns/100ps

module control_unit
	import cpu_types_pkg::*;
	import data_path_muxs_pkg::*;
(
	input  word_t       instruction,
	input  logic        equal,
	output logic        iren,
	output logic        dren,
	output logic        dwen,
	output logic        regwr,
	output logic        extend,
	output alu_src_t    alu_src,
	output pc_src_t     pc_src,
	output reg_dest_t   reg_dest,
	output mem_to_reg_t mem_to_reg,
	output aluop_t      aluop,
	output logic        halt
);

	opcode_t op_code;
	funct_t  funct;

	// only opcode and funct matter for decode
	assign op_code = opcode_t'(instruction[word_w-1 -: op_w]);
	assign funct = funct_t'(instruction[func_w-1:0]);

	always_comb begin
		// defaults form a no-op
		iren = 1'b1;
		dren = 1'b0;
		dwen = 1'b0;
		regwr = 1'b0;
		extend = 1'b0;
		alu_src = sel_reg_data;
		pc_src = sel_load_nxt_instr;
		reg_dest = sel_rt;
		mem_to_reg = sel_result;
		aluop = alu_add;
		halt = 1'b0;

		case (op_code)
			RTYPE: begin
				reg_dest = sel_rd;
				regwr = 1'b1;
				case (funct)
					SLL:  aluop = alu_sll;
					SRL:  aluop = alu_srl;
					ADDU: aluop = alu_add;
					SUBU: aluop = alu_sub;
					AND:  aluop = alu_and;
					OR:   aluop = alu_or;
					XOR:  aluop = alu_xor;
					NOR:  aluop = alu_nor;
					SLT:  aluop = alu_slt;
					SLTU: aluop = alu_sltu;
					JR: begin
						// jump to rs, nothing written
						regwr = 1'b0;
						pc_src = sel_load_jr_addr;
					end
					// unknown funct acts as a no-op
					default: regwr = 1'b0;
				endcase
			end
			// immediate arithmetic, signed extension
			ADDIU, SLTI, SLTIU: begin
				regwr = 1'b1;
				extend = 1'b1;
				alu_src = sel_imm16;
				case (op_code)
					SLTI:    aluop = alu_slt;
					SLTIU:   aluop = alu_sltu;
					default: aluop = alu_add;
				endcase
			end
			// immediate logic, zero extension
			ANDI, ORI, XORI: begin
				regwr = 1'b1;
				alu_src = sel_imm16;
				case (op_code)
					ANDI:    aluop = alu_and;
					ORI:     aluop = alu_or;
					default: aluop = alu_xor;
				endcase
			end
			LUI: begin
				regwr = 1'b1;
				mem_to_reg = sel_lui;
			end
			// address is rs plus signed offset
			LW: begin
				regwr = 1'b1;
				extend = 1'b1;
				alu_src = sel_imm16;
				dren = 1'b1;
				mem_to_reg = sel_mem;
			end
			SW: begin
				extend = 1'b1;
				alu_src = sel_imm16;
				dwen = 1'b1;
			end
			// branches compare by subtraction, equal is the alu zero flag
			BEQ: begin
				extend = 1'b1;
				aluop = alu_sub;
				if (equal)
					pc_src = sel_load_addr;
			end
			BNE: begin
				extend = 1'b1;
				aluop = alu_sub;
				if (!equal)
					pc_src = sel_load_addr;
			end
			J: pc_src = sel_load_addr;
			JAL: begin
				// return address into r31
				regwr = 1'b1;
				reg_dest = sel_ra;
				mem_to_reg = sel_pc4;
				pc_src = sel_load_addr;
			end
			HALT: begin
				iren = 1'b0;
				halt = 1'b1;
			end
			default: ;
		endcase
	end

endmodule

// File: design/cpu_types_pkg.sv
/*
  cpu types package
  instruction set encoding for the mips subset: field widths, opcodes, funct codes
*/

package cpu_types_pkg;

	// field and datapath widths
	localparam int word_w = 32;
	localparam int reg_w = 5;
	localparam int op_w = 6;
	localparam int func_w = 6;
	localparam int imm_w = 16;
	// jump target field of j and jal
	localparam int addr_w = 26;

	// data word and address
	typedef logic [word_w-1:0] word_t;

	// register index, 32 registers
	typedef logic [reg_w-1:0] regbits_t;

	// opcodes kept in the subset, i-type ones take their mips values
	typedef enum logic [op_w-1:0] {
		RTYPE = 6'b000000,
		J     = 6'b000010,
		JAL   = 6'b000011,
		BEQ   = 6'b000100,
		BNE   = 6'b000101,
		ADDIU = 6'b001001,
		SLTI  = 6'b001010,
		SLTIU = 6'b001011,
		ANDI  = 6'b001100,
		ORI   = 6'b001101,
		XORI  = 6'b001110,
		LUI   = 6'b001111,
		LW    = 6'b100011,
		SW    = 6'b101011,
		// not a mips opcode, stops the core
		HALT  = 6'b111111
	} opcode_t;

	// funct codes of the kept r-type instructions
	typedef enum logic [func_w-1:0] {
		SLL  = 6'h00,
		SRL  = 6'h02,
		JR   = 6'h08,
		ADDU = 6'h21,
		SUBU = 6'h23,
		AND  = 6'h24,
		OR   = 6'h25,
		XOR  = 6'h26,
		NOR  = 6'h27,
		SLT  = 6'h2a,
		SLTU = 6'h2b
	} funct_t;

endpackage

// File: design/data_path_muxs_pkg.sv
/*
  datapath mux package
  select encodings for the datapath muxes and the alu operation codes
*/

package data_path_muxs_pkg;

	// width of the alu operation code
	localparam int aluop_w = 4;

	// alu b operand
	typedef enum logic {
		sel_reg_data,
		sel_imm16
	} alu_src_t;

	// next pc source
	typedef enum logic [1:0] {
		sel_load_nxt_instr,
		// branch or jump target
		sel_load_addr,
		// value of rs
		sel_load_jr_addr
	} pc_src_t;

	// register write index
	typedef enum logic [1:0] {
		sel_rd,
		sel_rt,
		// r31 for jal
		sel_ra
	} reg_dest_t;

	// writeback data
	typedef enum logic [1:0] {
		sel_result,
		sel_mem,
		sel_pc4,
		sel_lui
	} mem_to_reg_t;

	// alu operations
	typedef enum logic [aluop_w-1:0] {
		alu_sll,
		alu_srl,
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_xor,
		alu_nor,
		alu_slt,
		alu_sltu
	} aluop_t;

endpackage

// File: design/program_counter.sv
/*
  program counter
  pc register with hold and the pc plus 4 address
*/

`timescale 1ns/100ps

module program_counter
	import cpu_types_pkg::*;
(
	input  logic  clk,
	input  logic  rst_n,
	input  logic  hold,
	input  word_t next_pc,
	output word_t pc,
	output word_t pc_plus4
);

	// fetch starts at address 0
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pc <= '0;
		end else if (!hold) begin
			pc <= next_pc;
		end
	end

	// sequential next instruction
	assign pc_plus4 = pc + word_t'(4);

	// branch and jump targets always carry two zero bits
	a_pc_aligned: assert property (@(posedge clk) disable iff (!rst_n)
		pc[1:0] == 2'b00);

endmodule

// File: design/register_file.sv
/*
  register file
  32 by 32-bit registers, two combinational reads, one clocked write, r0 reads zero
*/

`timescale 1ns/100ps

module register_file
	import cpu_types_pkg::*;
(
	input  logic     clk,
	input  logic     rst_n,
	input  logic     wen,
	input  regbits_t wsel,
	input  regbits_t rsel1,
	input  regbits_t rsel2,
	input  word_t    wdat,
	output word_t    rdat1,
	output word_t    rdat2
);

	word_t regs [2**reg_w];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < 2**reg_w; i++)
				regs[i] <= '0;
		end else if (wen && (wsel != '0)) begin
			// writes to r0 are dropped
			regs[wsel] <= wdat;
		end
	end

	// r0 is never written and keeps its reset zero
	// no bypass, a same-cycle write shows up next cycle
	assign rdat1 = regs[rsel1];
	assign rdat2 = regs[rsel2];

	a_r0_zero: assert property (@(posedge clk) disable iff (!rst_n)
		(rsel1 == '0) |-> (rdat1 == '0));

endmodule

// File: design/single_cycle_datapath.sv
/*
  single cycle datapath
  mips subset core: fetch, decode, execute, memory and writeback in one clock, with halt latch
*/

`timescale 1ns/100ps

module single_cycle_datapath
	import cpu_types_pkg::*;
	import data_path_muxs_pkg::*;
(
	input  logic  clk,
	input  logic  rst_n,
	output word_t iaddr,
	output logic  iren,
	input  word_t instruction,
	output word_t daddr,
	output word_t dstore,
	output logic  dren,
	output logic  dwen,
	input  word_t dload,
	output logic  halt
);

	// decoder outputs
	logic        cu_dwen, regwr, extend, equal, cu_halt;
	alu_src_t    alu_src;
	pc_src_t     pc_src;
	reg_dest_t   reg_dest;
	mem_to_reg_t mem_to_reg;
	aluop_t      aluop;

	// instruction fields
	regbits_t           rs, rt, rd;
	logic [4:0]         shamt;
	logic [imm_w-1:0]   imm16;
	logic [addr_w-1:0]  jaddr;

	word_t    imm_ext, rdat1, rdat2, alu_a, alu_b, result;
	word_t    pc, pc_plus4, next_pc, branch_target, jump_target, wdat;
	regbits_t wsel;
	logic     halt_q;

	assign rs = instruction[25:21];
	assign rt = instruction[20:16];
	assign rd = instruction[15:11];
	assign shamt = instruction[10:6];
	assign imm16 = instruction[imm_w-1:0];
	assign jaddr = instruction[addr_w-1:0];

	control_unit u_cu (
		.instruction(instruction),
		.equal(equal),
		.iren(iren),
		.dren(dren),
		.dwen(cu_dwen),
		.regwr(regwr),
		.extend(extend),
		.alu_src(alu_src),
		.pc_src(pc_src),
		.reg_dest(reg_dest),
		.mem_to_reg(mem_to_reg),
		.aluop(aluop),
		.halt(cu_halt)
	);

	// wen gated once halted
	register_file u_rf (
		.clk(clk),
		.rst_n(rst_n),
		.wen(regwr && !halt_q),
		.wsel(wsel),
		.rsel1(rs),
		.rsel2(rt),
		.wdat(wdat),
		.rdat1(rdat1),
		.rdat2(rdat2)
	);

	// sign or zero extension of the immediate
	assign imm_ext = extend ? {{(word_w-imm_w){imm16[imm_w-1]}}, imm16}
		: {{(word_w-imm_w){1'b0}}, imm16};

	// shifts take shamt on a and rt on b
	assign alu_a = (aluop == alu_sll || aluop == alu_srl) ? word_t'(shamt) : rdat1;
	assign alu_b = (alu_src == sel_imm16) ? imm_ext : rdat2;

	alu u_alu (
		.a(alu_a),
		.b(alu_b),
		.aluop(aluop),
		.result(result),
		.zero(equal)
	);

	// data memory port
	assign daddr = result;
	assign dstore = rdat2;
	assign dwen = cu_dwen && !halt_q;

	always_comb begin
		case (reg_dest)
			sel_rd:  wsel = rd;
			sel_ra:  wsel = regbits_t'(31);
			default: wsel = rt;
		endcase
	end

	always_comb begin
		case (mem_to_reg)
			sel_mem: wdat = dload;
			sel_pc4: wdat = pc_plus4;
			// lui fills the upper half
			sel_lui: wdat = {imm16, {(word_w-imm_w){1'b0}}};
			default: wdat = result;
		endcase
	end

	assign branch_target = pc_plus4 + {imm_ext[word_w-3:0], 2'b00};
	assign jump_target = {pc_plus4[word_w-1 -: word_w-addr_w-2], jaddr, 2'b00};

	// opcode bit 2 is clear for j and jal, set for beq and bne
	always_comb begin
		case (pc_src)
			sel_load_addr:    next_pc = instruction[28] ? branch_target : jump_target;
			sel_load_jr_addr: next_pc = rdat1;
			default:          next_pc = pc_plus4;
		endcase
	end

	// pc freezes from the halt instruction onwards
	program_counter u_pc (
		.clk(clk),
		.rst_n(rst_n),
		.hold(halt_q || cu_halt),
		.next_pc(next_pc),
		.pc(pc),
		.pc_plus4(pc_plus4)
	);

	assign iaddr = pc;

	// halt latch, sticky until reset
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			halt_q <= 1'b0;
		end else if (cu_halt) begin
			halt_q <= 1'b1;
		end
	end

	assign halt = halt_q;

endmodule

// File: run_sim.sh
#!/bin/sh
# build the single cycle datapath testbench with verilator and run it
# the exit status of the simulation binary carries pass or fail
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module single_cycle_datapath_tb \
	--Mdir obj_dir -o single_cycle_datapath_sim \
	-f single_cycle_datapath.f

./obj_dir/single_cycle_datapath_sim

// File: sim/datapath_golden.txt
// header: program word count, check count, byte address of the halt word
// then one program word per line, then data address and expected word pairs
00000036 00000019 000000C8
24140100 // 00 addiu r20, r0, 0x100   data base
24010005 // 04 addiu r1, r0, 5
2402FFFD // 08 addiu r2, r0, -3
00221821 // 0c addu  r3, r1, r2
00222023 // 10 subu  r4, r1, r2
0041282A // 14 slt   r5, r2, r1
0022302B // 18 sltu  r6, r1, r2
00013900 // 1c sll   r7, r1, 4
00024702 // 20 srl   r8, r2, 28
00224824 // 24 and   r9, r1, r2
00225025 // 28 or    r10, r1, r2
00225826 // 2c xor   r11, r1, r2
00226027 // 30 nor   r12, r1, r2
340D8000 // 34 ori   r13, r0, 0x8000
304EF0F0 // 38 andi  r14, r2, 0xf0f0
384F00FF // 3c xori  r15, r2, 0x00ff
2850FFFF // 40 slti  r16, r2, -1
2C31FFFF // 44 sltiu r17, r1, -1
3C121234 // 48 lui   r18, 0x1234
36525678 // 4c ori   r18, r18, 0x5678
AE830000 // 50 sw r3..r18 to 0x100..0x13c
AE840004
AE850008
AE86000C
AE870010
AE880014
AE890018
AE8A001C
AE8B0020
AE8C0024
AE8D0028
AE8E002C
AE8F0030
AE900034
AE910038
AE92003C
8E93001C // 90 lw  r19, 0x1c(r20)   reads the or result
AE930040 // 94 sw  r19, 0x40(r20)
10210001 // 98 beq r1, r1   taken
AE810044 // 9c marker, skipped
14220001 // a0 bne r1, r2   taken
AE810048 // a4 marker, skipped
10220001 // a8 beq r1, r2   not taken
AE81004C // ac marker, stored
14210001 // b0 bne r1, r1   not taken
AE810050 // b4 marker, stored
08000030 // b8 j   0xc0
AE810054 // bc marker, skipped
0C000034 // c0 jal 0xd0
AE9F0058 // c4 sw  r31, 0x58(r20)   return address
FC000000 // c8 halt
AE81005C // cc never reached
AE920060 // d0 sw  r18, 0x60(r20)   subroutine ran
03E00008 // d4 jr  r31
00000100 00000002 // addu
00000104 00000008 // subu
00000108 00000001 // slt
0000010C 00000001 // sltu
00000110 00000050 // sll
00000114 0000000F // srl
00000118 00000005 // and
0000011C FFFFFFFD // or
00000120 FFFFFFF8 // xor
00000124 00000002 // nor
00000128 00008000 // ori, zero extended
0000012C 0000F0F0 // andi
00000130 FFFFFF02 // xori
00000134 00000001 // slti, sign extended
00000138 00000001 // sltiu
0000013C 12345678 // lui then ori
00000140 FFFFFFFD // copy through lw
00000144 00000000 // beq taken
00000148 00000000 // bne taken
0000014C 00000005 // beq not taken
00000150 00000005 // bne not taken
00000154 00000000 // j skipped the marker
00000158 000000C4 // r31 after jal
0000015C 00000000 // store after halt
00000160 12345678 // jal target

// File: sim/memory_model.sv
/*
  memory model
  word-addressed testbench memory with a combinational read and a clocked write
*/

`timescale 1ns/100ps

module memory_model
	import cpu_types_pkg::*;
#(
	// address bits of the word index
	parameter int depth_w = 8
) (
	input  logic  clk,
	input  logic  wen,
	input  word_t addr,
	input  word_t wdata,
	output word_t rdata
);

	word_t              mem [2**depth_w];
	logic [depth_w-1:0] idx;

	// byte address, low two bits ignored
	assign idx = addr[depth_w+1:2];

	// every word starts at zero
	initial begin
		for (int i = 0; i < 2**depth_w; i++)
			mem[i[depth_w-1:0]] <= '0;
	end

	// write lands on the same edge as the core's register write
	always @(posedge clk) begin
		if (wen)
			mem[idx] <= wdata;
	end

	// read answers within the cycle
	assign rdata = mem[idx];

endmodule

// File: sim/single_cycle_datapath_tb.sv
/*
  single cycle datapath testbench
  loads the program and expected data words from the golden file, runs to halt, checks memory
*/

`timescale 1ns/100ps

module single_cycle_datapath_tb
	import cpu_types_pkg::*;
();

	// 10 ns clock
	localparam int half_period = 5;
	localparam int reset_cycles = 10;
	localparam int timeout_cycles = 2000;
	localparam int golden_depth = 128;
	// 256 words in each memory
	localparam int mem_depth_w = 8;

	logic  clk;
	logic  rst_n;
	word_t iaddr;
	word_t instruction;
	word_t daddr;
	word_t dstore;
	word_t dload;
	logic  iren;
	logic  dren;
	logic  dwen;
	logic  halt;

	// golden layout: word count, check count, halt pc, program, then address and value pairs
	word_t golden [golden_depth];
	int    prog_words;
	int    check_count;
	word_t halt_pc;

	single_cycle_datapath UUT (
		.clk(clk),
		.rst_n(rst_n),
		.iaddr(iaddr),
		.iren(iren),
		.instruction(instruction),
		.daddr(daddr),
		.dstore(dstore),
		.dren(dren),
		.dwen(dwen),
		.dload(dload),
		.halt(halt)
	);

	// instruction memory, filled from the golden file, write port idle
	memory_model #(.depth_w(mem_depth_w)) imem (
		.clk(clk),
		.wen(1'b0),
		.addr(iaddr),
		.wdata('0),
		.rdata(instruction)
	);

	// data memory, written only by the core
	memory_model #(.depth_w(mem_depth_w)) dmem (
		.clk(clk),
		.wen(dwen),
		.addr(daddr),
		.wdata(dstore),
		.rdata(dload)
	);

	initial begin
		clk = 1'b0;
		forever #(half_period) clk = ~clk;
	end

	task automatic check_value(input string what, input word_t actual, input word_t expected);
		if (actual !== expected) begin
			$display("MISMATCH at time %0t: %s is 0x%08h, expected 0x%08h",
				$time, what, actual, expected);
			$display("Result: FAILED");
			$fatal(1, "check failed");
		end
	endtask

	// fetch and data memory enables follow the opcode on the bus
	task automatic check_enables();
		logic [op_w-1:0] opcode;

		opcode = instruction[word_w-1 -: op_w];
		// a halted core stops fetching
		check_value("iren", word_t'(iren), word_t'(opcode != HALT));
		check_value("dren", word_t'(dren), word_t'(opcode == LW));
		check_value("dwen", word_t'(dwen), word_t'(opcode == SW && !halt));
	endtask

	initial begin
		int    i;
		int    cycles;
		word_t addr;
		word_t expected;

		rst_n = 1'b0;
		golden = '{default: '0};
		$readmemh("sim/datapath_golden.txt", golden);
		prog_words = int'(golden[0]);
		check_count = int'(golden[1]);
		halt_pc = golden[2];
		if (prog_words == 0 || prog_words > 2**mem_depth_w
				|| 3 + prog_words + 2 * check_count > golden_depth) begin
			$display("golden file is missing or its header is out of range");
			$display("Result: FAILED");
			$fatal(1, "bad golden file");
		end

		// zero fill settles at time 0, so the program goes in on the first edge
		@(posedge clk);
		for (i = 0; i < prog_words; i++)
			imem.mem[i[mem_depth_w-1:0]] <= golden[3 + i];

		// rest of the reset pulse
		for (i = 1; i < reset_cycles; i++)
			@(posedge clk);
		rst_n <= 1'b1;

		// run to halt, sampled away from the active edge
		cycles = 0;
		while (!halt && cycles < timeout_cycles) begin
			@(negedge clk);
			cycles++;
			check_enables();
		end
		if (!halt) begin
			$display("timeout: the core never halted within %0d cycles", timeout_cycles);
			$display("Result: FAILED");
			$fatal(1, "no halt");
		end

		// pc parks on the halt word and stays there
		check_value("pc at halt", iaddr, halt_pc);
		for (i = 0; i < 4; i++)
			@(negedge clk);
		check_value("pc after halt", iaddr, halt_pc);
		check_value("halt level", word_t'(halt), word_t'(1));
		check_enables();

		// expected data memory image
		for (i = 0; i < check_count; i++) begin
			addr = golden[3 + prog_words + 2 * i];
			expected = golden[4 + prog_words + 2 * i];
			check_value($sformatf("data word at 0x%08h", addr),
				dmem.mem[addr[mem_depth_w+1:2]], expected);
		end

		$display("Result: PASSED");
		$finish;
	end

endmodule

// File: single_cycle_datapath.f
design/cpu_types_pkg.sv
design/data_path_muxs_pkg.sv
design/control_unit.sv
design/alu.sv
design/register_file.sv
design/program_counter.sv
design/single_cycle_datapath.sv
sim/memory_model.sv
sim/single_cycle_datapath_tb.sv
